//--- procyon_types.sv
////////////////////////////////////////////////////////////////////////////
// Widths and data types shared by the integer execution unit
// Data and address words are the same width (RV32)
////////////////////////////////////////////////////////////////////////////

package procyon_types;

    localparam DATA_WIDTH = 32;
    localparam ADDR_WIDTH = 32;

    // Reorder buffer holds up to 64 entries
    localparam TAG_WIDTH = 6;

    // Enough bits to shift across a full data word
    localparam SHAMT_WIDTH = $clog2(DATA_WIDTH);

    // One operand or result word
    typedef logic [DATA_WIDTH-1:0] procyon_data_t;

    // Instruction address
    typedef logic [ADDR_WIDTH-1:0] procyon_addr_t;

    // Reorder buffer tag carried with each instruction
    typedef logic [TAG_WIDTH-1:0] procyon_tag_t;

    typedef logic [SHAMT_WIDTH-1:0] procyon_shamt_t;

endpackage

//--- procyon_isa.sv
////////////////////////////////////////////////////////////////////////////
// RV32I encodings used by the integer execution unit
// Only the opcodes that the unit executes are listed
////////////////////////////////////////////////////////////////////////////

package procyon_isa;

    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011
    } procyon_opcode_t;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // funct3 for JALR
    localparam logic [2:0] F3_JALR = 3'b000;

    // funct7 selecting SUB over ADD and SRA over SRL
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_FUNC_ADD  = 4'b0000,
        ALU_FUNC_SUB  = 4'b0001,
        ALU_FUNC_AND  = 4'b0010,
        ALU_FUNC_OR   = 4'b0011,
        ALU_FUNC_XOR  = 4'b0100,
        ALU_FUNC_SLL  = 4'b0101,
        ALU_FUNC_SRL  = 4'b0110,
        ALU_FUNC_SRA  = 4'b0111,
        ALU_FUNC_SLT  = 4'b1000,
        ALU_FUNC_SLTU = 4'b1001,
        // Branch compares
        ALU_FUNC_EQ   = 4'b1010,
        ALU_FUNC_NE   = 4'b1011,
        ALU_FUNC_LT   = 4'b1100,
        ALU_FUNC_GE   = 4'b1101,
        ALU_FUNC_LTU  = 4'b1110,
        ALU_FUNC_GEU  = 4'b1111
    } procyon_alu_func_t;

endpackage

//--- ieu_stage_reg.sv
////////////////////////////////////////////////////////////////////////////
// Pipeline register with a valid bit; flush drops the entry in one edge
// Payload is only captured for valid entries and has no reset
////////////////////////////////////////////////////////////////////////////

module ieu_stage_reg #(
    parameter type T_PAYLOAD = logic
) (
    input  logic     clk,
    input  logic     n_rst,

    input  logic     i_flush,

    input  logic     i_valid,
    input  T_PAYLOAD i_payload,

    output logic     o_valid,
    output T_PAYLOAD o_payload
);

    logic     valid_q;
    T_PAYLOAD payload_q;

    always_ff @(posedge clk, negedge n_rst) begin
        if (~n_rst) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            payload_q <= i_payload;
        end
    end

    assign o_valid   = valid_q;
    assign o_payload = payload_q;

    // Nothing survives a flush edge
    assert property (@(posedge clk) disable iff (~n_rst) i_flush |=> ~o_valid);

endmodule

//--- ieu_id.sv
////////////////////////////////////////////////////////////////////////////
// Decode stage; purely combinational, opcode comes from the issue queue
// Only OP, OP_IMM, LUI, AUIPC, JAL, JALR and BRANCH are expected
////////////////////////////////////////////////////////////////////////////

module ieu_id (
    input  logic                            i_valid,
    input  procyon_isa::procyon_opcode_t    i_opcode,
    input  procyon_types::procyon_addr_t    i_iaddr,
    input  procyon_types::procyon_data_t    i_insn,
    input  procyon_types::procyon_data_t    i_src_a,
    input  procyon_types::procyon_data_t    i_src_b,
    input  procyon_types::procyon_tag_t     i_tag,

    output logic                            o_valid,
    output procyon_isa::procyon_alu_func_t  o_alu_func,
    output procyon_types::procyon_data_t    o_src_a,
    output procyon_types::procyon_data_t    o_src_b,
    output procyon_types::procyon_addr_t    o_iaddr,
    output procyon_types::procyon_data_t    o_imm_b,
    output procyon_types::procyon_shamt_t   o_shamt,
    output procyon_types::procyon_tag_t     o_tag,
    output logic                            o_jmp,
    output logic                            o_br
);

    procyon_types::procyon_data_t imm_i;
    procyon_types::procyon_data_t imm_u;
    procyon_types::procyon_data_t imm_j;
    logic [2:0]                   funct3;
    logic [6:0]                   funct7;
    logic                         alt;

    assign funct3 = i_insn[14:12];
    assign funct7 = i_insn[31:25];
    assign alt    = (funct7 == procyon_isa::F7_ALT);

    // Sign extended immediates
    assign imm_i   = {{20{i_insn[31]}}, i_insn[31:20]};
    assign imm_u   = {i_insn[31:12], 12'b0};
    assign imm_j   = {{12{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
    assign o_imm_b = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};

    always_comb begin
        o_alu_func = procyon_isa::ALU_FUNC_ADD;
        case (i_opcode)
            procyon_isa::OPCODE_OP, procyon_isa::OPCODE_OP_IMM: begin
                case (funct3)
                    // ADDI has no subtract form
                    procyon_isa::F3_ADD_SUB: begin
                        o_alu_func = (i_opcode == procyon_isa::OPCODE_OP && alt) ?
                                     procyon_isa::ALU_FUNC_SUB : procyon_isa::ALU_FUNC_ADD;
                    end
                    procyon_isa::F3_SLL:  o_alu_func = procyon_isa::ALU_FUNC_SLL;
                    procyon_isa::F3_SLT:  o_alu_func = procyon_isa::ALU_FUNC_SLT;
                    procyon_isa::F3_SLTU: o_alu_func = procyon_isa::ALU_FUNC_SLTU;
                    procyon_isa::F3_XOR:  o_alu_func = procyon_isa::ALU_FUNC_XOR;
                    procyon_isa::F3_SRL_SRA: begin
                        o_alu_func = alt ? procyon_isa::ALU_FUNC_SRA : procyon_isa::ALU_FUNC_SRL;
                    end
                    procyon_isa::F3_OR:   o_alu_func = procyon_isa::ALU_FUNC_OR;
                    default:              o_alu_func = procyon_isa::ALU_FUNC_AND;
                endcase
            end
            procyon_isa::OPCODE_BRANCH: begin
                case (funct3)
                    procyon_isa::F3_BEQ:  o_alu_func = procyon_isa::ALU_FUNC_EQ;
                    procyon_isa::F3_BNE:  o_alu_func = procyon_isa::ALU_FUNC_NE;
                    procyon_isa::F3_BLT:  o_alu_func = procyon_isa::ALU_FUNC_LT;
                    procyon_isa::F3_BGE:  o_alu_func = procyon_isa::ALU_FUNC_GE;
                    procyon_isa::F3_BLTU: o_alu_func = procyon_isa::ALU_FUNC_LTU;
                    procyon_isa::F3_BGEU: o_alu_func = procyon_isa::ALU_FUNC_GEU;
                    default:              o_alu_func = procyon_isa::ALU_FUNC_EQ;
                endcase
            end
            // LUI, AUIPC and the jumps all add
            default: o_alu_func = procyon_isa::ALU_FUNC_ADD;
        endcase
    end

    always_comb begin
        o_src_a = i_src_a;
        o_src_b = i_src_b;
        case (i_opcode)
            procyon_isa::OPCODE_OP_IMM: o_src_b = imm_i;
            procyon_isa::OPCODE_LUI: begin
                o_src_a = '0;
                o_src_b = imm_u;
            end
            procyon_isa::OPCODE_AUIPC: begin
                o_src_a = i_iaddr;
                o_src_b = imm_u;
            end
            procyon_isa::OPCODE_JAL: begin
                o_src_a = i_iaddr;
                o_src_b = imm_j;
            end
            procyon_isa::OPCODE_JALR: o_src_b = imm_i;
            default: begin
                o_src_a = i_src_a;
                o_src_b = i_src_b;
            end
        endcase
    end

    // Immediate shifts take shamt from the instruction itself
    assign o_shamt = (i_opcode == procyon_isa::OPCODE_OP_IMM) ? i_insn[24:20] : i_src_b[4:0];

    assign o_jmp   = (i_opcode == procyon_isa::OPCODE_JAL) ||
                     (i_opcode == procyon_isa::OPCODE_JALR);
    assign o_br    = (i_opcode == procyon_isa::OPCODE_BRANCH);

    assign o_valid = i_valid;
    assign o_iaddr = i_iaddr;
    assign o_tag   = i_tag;

endmodule

//--- ieu_ex.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage; ALU, branch compare and next address, all combinational
// Jump targets have bit 0 cleared as JALR requires
////////////////////////////////////////////////////////////////////////////

module ieu_ex (
    input  logic                            i_valid,
    input  procyon_isa::procyon_alu_func_t  i_alu_func,
    input  procyon_types::procyon_data_t    i_src_a,
    input  procyon_types::procyon_data_t    i_src_b,
    input  procyon_types::procyon_addr_t    i_iaddr,
    input  procyon_types::procyon_data_t    i_imm_b,
    input  procyon_types::procyon_shamt_t   i_shamt,
    input  procyon_types::procyon_tag_t     i_tag,
    input  logic                            i_jmp,
    input  logic                            i_br,

    output logic                            o_valid,
    output procyon_types::procyon_data_t    o_data,
    output procyon_types::procyon_addr_t    o_addr,
    output procyon_types::procyon_tag_t     o_tag,
    output logic                            o_redirect
);

    procyon_types::procyon_data_t alu_result;
    procyon_types::procyon_addr_t iaddr_next;
    procyon_types::procyon_addr_t br_target;
    logic                         eq;
    logic                         lt_s;
    logic                         lt_u;
    logic                         taken;

    assign eq   = (i_src_a == i_src_b);
    assign lt_s = ($signed(i_src_a) < $signed(i_src_b));
    assign lt_u = (i_src_a < i_src_b);

    always_comb begin
        case (i_alu_func)
            procyon_isa::ALU_FUNC_ADD:  alu_result = i_src_a + i_src_b;
            procyon_isa::ALU_FUNC_SUB:  alu_result = i_src_a - i_src_b;
            procyon_isa::ALU_FUNC_AND:  alu_result = i_src_a & i_src_b;
            procyon_isa::ALU_FUNC_OR:   alu_result = i_src_a | i_src_b;
            procyon_isa::ALU_FUNC_XOR:  alu_result = i_src_a ^ i_src_b;
            procyon_isa::ALU_FUNC_SLL:  alu_result = i_src_a << i_shamt;
            procyon_isa::ALU_FUNC_SRL:  alu_result = i_src_a >> i_shamt;
            procyon_isa::ALU_FUNC_SRA:  alu_result = $unsigned($signed(i_src_a) >>> i_shamt);
            procyon_isa::ALU_FUNC_SLT:  alu_result = procyon_types::procyon_data_t'(lt_s);
            procyon_isa::ALU_FUNC_SLTU: alu_result = procyon_types::procyon_data_t'(lt_u);
            // Compares feed the branch decision, not the result
            default:                    alu_result = '0;
        endcase
    end

    always_comb begin
        case (i_alu_func)
            procyon_isa::ALU_FUNC_EQ:  taken = eq;
            procyon_isa::ALU_FUNC_NE:  taken = ~eq;
            procyon_isa::ALU_FUNC_LT:  taken = lt_s;
            procyon_isa::ALU_FUNC_GE:  taken = ~lt_s;
            procyon_isa::ALU_FUNC_LTU: taken = lt_u;
            procyon_isa::ALU_FUNC_GEU: taken = ~lt_u;
            default:                   taken = 1'b0;
        endcase
    end

    assign iaddr_next = i_iaddr + procyon_types::procyon_addr_t'(4);
    assign br_target  = i_iaddr + i_imm_b;

    always_comb begin
        if (i_jmp) begin
            // Link value goes to rd, target to the fetch unit
            o_data     = iaddr_next;
            o_addr     = {alu_result[procyon_types::ADDR_WIDTH-1:1], 1'b0};
            o_redirect = 1'b1;
        end else if (i_br) begin
            o_data     = '0;
            o_addr     = taken ? br_target : iaddr_next;
            o_redirect = taken;
        end else begin
            o_data     = alu_result;
            o_addr     = iaddr_next;
            o_redirect = 1'b0;
        end
    end

    assign o_valid = i_valid;
    assign o_tag   = i_tag;

    // Only control flow instructions may steer fetch
    always_comb begin
        if (i_valid) begin
            assert (~o_redirect || i_jmp || i_br);
        end
    end

endmodule

//--- ieu.sv
////////////////////////////////////////////////////////////////////////////
// Integer execution unit; ID and EX stages, result on the CDB 2 edges on
// Never stalls; i_flush drops everything in flight
////////////////////////////////////////////////////////////////////////////

module ieu (
    input  logic                            clk,
    input  logic                            n_rst,

    input  logic                            i_flush,

    // From the reservation station
    input  logic                            i_fu_valid,
    input  procyon_isa::procyon_opcode_t    i_fu_opcode,
    input  procyon_types::procyon_addr_t    i_fu_iaddr,
    input  procyon_types::procyon_data_t    i_fu_insn,
    input  procyon_types::procyon_data_t    i_fu_src_a,
    input  procyon_types::procyon_data_t    i_fu_src_b,
    input  procyon_types::procyon_tag_t     i_fu_tag,

    // Common data bus
    output logic                            o_cdb_en,
    output logic                            o_cdb_redirect,
    output procyon_types::procyon_data_t    o_cdb_data,
    output procyon_types::procyon_addr_t    o_cdb_addr,
    output procyon_types::procyon_tag_t     o_cdb_tag
);

    typedef struct packed {
        procyon_isa::procyon_alu_func_t alu_func;
        procyon_types::procyon_data_t   src_a;
        procyon_types::procyon_data_t   src_b;
        procyon_types::procyon_addr_t   iaddr;
        procyon_types::procyon_data_t   imm_b;
        procyon_types::procyon_shamt_t  shamt;
        procyon_types::procyon_tag_t    tag;
        logic                           jmp;
        logic                           br;
    } id_payload_t;

    typedef struct packed {
        procyon_types::procyon_data_t   data;
        procyon_types::procyon_addr_t   addr;
        procyon_types::procyon_tag_t    tag;
        logic                           redirect;
    } ex_payload_t;

    logic        id_valid;
    logic        id_valid_q;
    id_payload_t id_payload;
    id_payload_t id_payload_q;
    logic        ex_valid;
    ex_payload_t ex_payload;
    ex_payload_t ex_payload_q;

    ieu_id ieu_id_i (
        .i_valid    (i_fu_valid),
        .i_opcode   (i_fu_opcode),
        .i_iaddr    (i_fu_iaddr),
        .i_insn     (i_fu_insn),
        .i_src_a    (i_fu_src_a),
        .i_src_b    (i_fu_src_b),
        .i_tag      (i_fu_tag),
        .o_valid    (id_valid),
        .o_alu_func (id_payload.alu_func),
        .o_src_a    (id_payload.src_a),
        .o_src_b    (id_payload.src_b),
        .o_iaddr    (id_payload.iaddr),
        .o_imm_b    (id_payload.imm_b),
        .o_shamt    (id_payload.shamt),
        .o_tag      (id_payload.tag),
        .o_jmp      (id_payload.jmp),
        .o_br       (id_payload.br)
    );

    ieu_stage_reg #(.T_PAYLOAD(id_payload_t)) id_ex_reg_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_flush   (i_flush),
        .i_valid   (id_valid),
        .i_payload (id_payload),
        .o_valid   (id_valid_q),
        .o_payload (id_payload_q)
    );

    ieu_ex ieu_ex_i (
        .i_valid    (id_valid_q),
        .i_alu_func (id_payload_q.alu_func),
        .i_src_a    (id_payload_q.src_a),
        .i_src_b    (id_payload_q.src_b),
        .i_iaddr    (id_payload_q.iaddr),
        .i_imm_b    (id_payload_q.imm_b),
        .i_shamt    (id_payload_q.shamt),
        .i_tag      (id_payload_q.tag),
        .i_jmp      (id_payload_q.jmp),
        .i_br       (id_payload_q.br),
        .o_valid    (ex_valid),
        .o_data     (ex_payload.data),
        .o_addr     (ex_payload.addr),
        .o_tag      (ex_payload.tag),
        .o_redirect (ex_payload.redirect)
    );

    ieu_stage_reg #(.T_PAYLOAD(ex_payload_t)) ex_cdb_reg_i (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_flush   (i_flush),
        .i_valid   (ex_valid),
        .i_payload (ex_payload),
        .o_valid   (o_cdb_en),
        .o_payload (ex_payload_q)
    );

    assign o_cdb_data     = ex_payload_q.data;
    assign o_cdb_addr     = ex_payload_q.addr;
    assign o_cdb_tag      = ex_payload_q.tag;
    assign o_cdb_redirect = ex_payload_q.redirect;

endmodule

//--- ieu_tb.sv
////////////////////////////////////////////////////////////////////////////
// Directed table then a seeded random ALU stream, checked on the CDB
// Each entry is issued for one cycle; its result is checked 2 cycles later
////////////////////////////////////////////////////////////////////////////

module ieu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct {
        logic                          valid;
        logic                          flush;
        procyon_isa::procyon_opcode_t  opcode;
        procyon_types::procyon_data_t  insn;
        procyon_types::procyon_addr_t  iaddr;
        procyon_types::procyon_data_t  src_a;
        procyon_types::procyon_data_t  src_b;
        procyon_types::procyon_tag_t   tag;
        logic                          exp_en;
        procyon_types::procyon_data_t  exp_data;
        procyon_types::procyon_addr_t  exp_addr;
        logic                          exp_redirect;
    } entry_t;

    logic                          clk = 1'b0;
    logic                          n_rst;
    logic                          i_flush;
    logic                          i_fu_valid;
    procyon_isa::procyon_opcode_t  i_fu_opcode;
    procyon_types::procyon_addr_t  i_fu_iaddr;
    procyon_types::procyon_data_t  i_fu_insn;
    procyon_types::procyon_data_t  i_fu_src_a;
    procyon_types::procyon_data_t  i_fu_src_b;
    procyon_types::procyon_tag_t   i_fu_tag;
    logic                          o_cdb_en;
    logic                          o_cdb_redirect;
    procyon_types::procyon_data_t  o_cdb_data;
    procyon_types::procyon_addr_t  o_cdb_addr;
    procyon_types::procyon_tag_t   o_cdb_tag;

    entry_t                        table_q[$];
    procyon_types::procyon_addr_t  next_iaddr = 32'h0000_1000;
    int                            seed = 32'hafbdf0ae;
    int                            errors = 0;
    int                            checks = 0;
    int                            cycles = 0;
    int                            cycle_limit = 0;

    ieu ieu_i (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_flush        (i_flush),
        .i_fu_valid     (i_fu_valid),
        .i_fu_opcode    (i_fu_opcode),
        .i_fu_iaddr     (i_fu_iaddr),
        .i_fu_insn      (i_fu_insn),
        .i_fu_src_a     (i_fu_src_a),
        .i_fu_src_b     (i_fu_src_b),
        .i_fu_tag       (i_fu_tag),
        .o_cdb_en       (o_cdb_en),
        .o_cdb_redirect (o_cdb_redirect),
        .o_cdb_data     (o_cdb_data),
        .o_cdb_addr     (o_cdb_addr),
        .o_cdb_tag      (o_cdb_tag)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] rtype_insn(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, procyon_isa::OPCODE_OP};
    endfunction

    function automatic logic [31:0] itype_insn(input procyon_isa::procyon_opcode_t op,
                                               input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'd1, f3, 5'd3, op};
    endfunction

    function automatic logic [31:0] utype_insn(input procyon_isa::procyon_opcode_t op,
                                               input logic [19:0] imm);
        return {imm, 5'd3, op};
    endfunction

    function automatic logic [31:0] jtype_insn(input int imm);
        logic [20:0] j;
        j = imm[20:0];
        return {j[20], j[10:1], j[11], j[19:12], 5'd1, procyon_isa::OPCODE_JAL};
    endfunction

    function automatic logic [31:0] btype_insn(input logic [2:0] f3, input int imm);
        logic [12:0] b;
        b = imm[12:0];
        return {b[12], b[10:5], 5'd2, 5'd1, f3, b[4:1], b[11], procyon_isa::OPCODE_BRANCH};
    endfunction

    // Reference model of the ADD, SUB, XOR and SLTU ops in the random stream
    function automatic logic [31:0] alu_model(input logic [1:0] sel, input logic [31:0] a,
                                              input logic [31:0] b);
        case (sel)
            2'd0:    return a + b;
            2'd1:    return a - b;
            2'd2:    return a ^ b;
            default: return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    task automatic append_entry(input logic valid, input logic [31:0] insn,
                                input logic [31:0] a, input logic [31:0] b,
                                input logic [31:0] data, input logic [31:0] addr,
                                input logic redirect);
        entry_t e;
        e.valid        = valid;
        e.flush        = 1'b0;
        e.opcode       = procyon_isa::procyon_opcode_t'(insn[6:0]);
        e.insn         = insn;
        e.iaddr        = next_iaddr;
        e.src_a        = a;
        e.src_b        = b;
        e.tag          = 6'(table_q.size());
        e.exp_en       = valid;
        e.exp_data     = data;
        e.exp_addr     = addr;
        e.exp_redirect = redirect;
        table_q.push_back(e);
        next_iaddr     = next_iaddr + 32'd4;
    endtask

    task automatic idle_entry();
        append_entry(1'b0, rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_ADD_SUB), 0, 0,
                     0, 0, 1'b0);
    endtask

    task automatic alu_entry(input logic [31:0] insn, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] data);
        append_entry(1'b1, insn, a, b, data, next_iaddr + 32'd4, 1'b0);
    endtask

    task automatic jump_entry(input logic [31:0] insn, input logic [31:0] a,
                              input logic [31:0] target);
        append_entry(1'b1, insn, a, 0, next_iaddr + 32'd4, target, 1'b1);
    endtask

    task automatic branch_entry(input logic [2:0] f3, input int imm, input logic [31:0] a,
                                input logic [31:0] b, input logic taken);
        append_entry(1'b1, btype_insn(f3, imm), a, b, 0,
                     taken ? next_iaddr + imm : next_iaddr + 32'd4, taken);
    endtask

    // Flush on the newest entry drops it and the one issued just before
    task automatic flush_last();
        int n;
        n = table_q.size() - 1;
        table_q[n].flush  = 1'b1;
        table_q[n].exp_en = 1'b0;
        table_q[n-1].exp_en = 1'b0;
    endtask

    task automatic directed_entries();
        idle_entry();
        idle_entry();
        alu_entry(rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_ADD_SUB), 5, 7, 12);
        alu_entry(rtype_insn(procyon_isa::F7_ALT, procyon_isa::F3_ADD_SUB), 3, 5, 32'hfffffffe);
        alu_entry(rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_AND),
                  32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000);
        alu_entry(rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_OR),
                  32'h0f0f0000, 32'h000000ff, 32'h0f0f00ff);
        alu_entry(itype_insn(procyon_isa::OPCODE_OP_IMM, 12'h7ff, procyon_isa::F3_XOR),
                  32'h12345678, 0, 32'h12345187);
        // Only the low 5 bits of src_b shift
        alu_entry(rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_SLL), 1, 32'h24, 32'h10);
        alu_entry(itype_insn(procyon_isa::OPCODE_OP_IMM, {procyon_isa::F7_ALT, 5'd4},
                  procyon_isa::F3_SRL_SRA), 32'h80000000, 0, 32'hf8000000);
        alu_entry(rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_SRL_SRA),
                  32'h80000000, 4, 32'h08000000);
        alu_entry(rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_SLT), 32'hffffffff, 1, 1);
        alu_entry(rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_SLTU), 32'hffffffff, 1, 0);
        alu_entry(itype_insn(procyon_isa::OPCODE_OP_IMM, 12'hfff, procyon_isa::F3_SLT),
                  32'hfffffffe, 0, 1);
        alu_entry(utype_insn(procyon_isa::OPCODE_LUI, 20'habcde), 32'h55, 0, 32'habcde000);
        alu_entry(utype_insn(procyon_isa::OPCODE_AUIPC, 20'h00001), 0, 0,
                  next_iaddr + 32'h1000);
        jump_entry(jtype_insn(32'h10), 0, next_iaddr + 32'h10);
        jump_entry(jtype_insn(-8), 0, next_iaddr - 32'd8);
        jump_entry(itype_insn(procyon_isa::OPCODE_JALR, 12'h005, procyon_isa::F3_JALR),
                   32'h2000, 32'h2004);
        jump_entry(itype_insn(procyon_isa::OPCODE_JALR, 12'hffd, procyon_isa::F3_JALR),
                   32'h2000, 32'h1ffc);
        branch_entry(procyon_isa::F3_BEQ, -16, 5, 5, 1'b1);
        branch_entry(procyon_isa::F3_BEQ, 32'h20, 5, 6, 1'b0);
        branch_entry(procyon_isa::F3_BNE, 32'h800, 5, 6, 1'b1);
        branch_entry(procyon_isa::F3_BNE, 32'h20, 5, 5, 1'b0);
        branch_entry(procyon_isa::F3_BLT, 32'h20, 32'hffffffff, 1, 1'b1);
        branch_entry(procyon_isa::F3_BLT, 32'h20, 1, 32'hffffffff, 1'b0);
        branch_entry(procyon_isa::F3_BGE, 32'h20, 7, 7, 1'b1);
        branch_entry(procyon_isa::F3_BGE, 32'h20, 32'hffffffff, 1, 1'b0);
        branch_entry(procyon_isa::F3_BLTU, 32'h20, 1, 32'hffffffff, 1'b1);
        branch_entry(procyon_isa::F3_BLTU, 32'h20, 32'hffffffff, 1, 1'b0);
        branch_entry(procyon_isa::F3_BGEU, 32'h20, 32'hffffffff, 1, 1'b1);
        branch_entry(procyon_isa::F3_BGEU, 32'h20, 1, 32'hffffffff, 1'b0);
        alu_entry(rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_ADD_SUB), 1, 1, 2);
        alu_entry(rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_ADD_SUB), 2, 2, 4);
        alu_entry(rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_ADD_SUB), 3, 3, 6);
        flush_last();
        alu_entry(rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_ADD_SUB), 4, 4, 8);
    endtask

    task automatic random_alu_entries(input int count);
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] insn;
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            a   = $random(seed);
            b   = $random(seed);
            case (rnd[1:0])
                2'd0:    insn = rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_ADD_SUB);
                2'd1:    insn = rtype_insn(procyon_isa::F7_ALT, procyon_isa::F3_ADD_SUB);
                2'd2:    insn = rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_XOR);
                default: insn = rtype_insn(procyon_isa::F7_BASE, procyon_isa::F3_SLTU);
            endcase
            alu_entry(insn, a, b, alu_model(rnd[1:0], a, b));
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_entry(input int idx);
        entry_t e;
        e = table_q[idx];
        check_value($sformatf("o_cdb_en (entry %0d)", idx), 32'(o_cdb_en), 32'(e.exp_en));
        if (e.exp_en) begin
            check_value($sformatf("o_cdb_data (entry %0d)", idx), o_cdb_data, e.exp_data);
            check_value($sformatf("o_cdb_addr (entry %0d)", idx), o_cdb_addr, e.exp_addr);
            check_value($sformatf("o_cdb_tag (entry %0d)", idx), 32'(o_cdb_tag), 32'(e.tag));
            check_value($sformatf("o_cdb_redirect (entry %0d)", idx), 32'(o_cdb_redirect),
                        32'(e.exp_redirect));
        end
    endtask

    initial begin
        int directed_len;
        n_rst       <= 1'b0;
        i_flush     <= 1'b0;
        i_fu_valid  <= 1'b0;
        i_fu_opcode <= procyon_isa::OPCODE_OP;
        i_fu_iaddr  <= '0;
        i_fu_insn   <= '0;
        i_fu_src_a  <= '0;
        i_fu_src_b  <= '0;
        i_fu_tag    <= '0;

        directed_entries();
        directed_len = table_q.size();
        random_alu_entries(64);
        cycle_limit  = (directed_len + 64 + 10) * 2;

        repeat (2) @(posedge clk);
        n_rst <= 1'b1;

        for (int k = 0; k < table_q.size() + 2; k++) begin
            @(posedge clk);
            if (k < table_q.size()) begin
                i_flush     <= table_q[k].flush;
                i_fu_valid  <= table_q[k].valid;
                i_fu_opcode <= table_q[k].opcode;
                i_fu_iaddr  <= table_q[k].iaddr;
                i_fu_insn   <= table_q[k].insn;
                i_fu_src_a  <= table_q[k].src_a;
                i_fu_src_b  <= table_q[k].src_b;
                i_fu_tag    <= table_q[k].tag;
            end else begin
                i_flush    <= 1'b0;
                i_fu_valid <= 1'b0;
            end
            @(negedge clk);
            if (k >= 2) begin
                check_entry(k - 2);
            end
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- ieu.f
procyon_types.sv
procyon_isa.sv
ieu_stage_reg.sv
ieu_id.sv
ieu_ex.sv
ieu.sv
ieu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ieu_tb
FILELIST  ?= ieu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf $(BUILD_DIR)
